/* rv_isa_pkg.sv */
package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  localparam int num_regs = 32;

  // major opcodes of the supported subset
  localparam opcode_t op_arith = 7'b0110011;
  localparam opcode_t op_arith_imm = 7'b0010011;
  localparam opcode_t op_load = 7'b0000011;
  localparam opcode_t op_store = 7'b0100011;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_jal = 7'b1101111;
  localparam opcode_t op_jalr = 7'b1100111;
  localparam opcode_t op_ecall = 7'b1110011; // shares the system opcode

  // register and immediate arithmetic
  localparam funct3_t f3_add = 3'b000;
  localparam funct3_t f3_sll = 3'b001;
  localparam funct3_t f3_xor = 3'b100;
  localparam funct3_t f3_srl = 3'b101;
  localparam funct3_t f3_or = 3'b110;
  localparam funct3_t f3_and = 3'b111;

  // branch conditions
  localparam funct3_t f3_beq = 3'b000;
  localparam funct3_t f3_bne = 3'b001;
  localparam funct3_t f3_blt = 3'b100;
  localparam funct3_t f3_bge = 3'b101;

  localparam funct7_t f7_sub = 7'b0100000;

endpackage

/* cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

  // encodings follow funct3 where the operation has one
  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sub = 3'b010,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or = 3'b110,
    alu_and = 3'b111
  } alu_op_t;

  typedef struct packed {
    logic is_jal;
    logic is_jalr;
    logic branch;
    logic mem_read;
    logic mem_write;
    logic mem_to_reg; // write back the loaded word
    logic alu_src; // second operand is the immediate
    logic reg_write;
    logic pc_to_reg; // write back the return address
    logic is_ecall;
  } ctrl_t;

endpackage

/* fetch_unit.sv */
module fetch_unit #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic clk,
  input  logic reset,
  input  cpu_ctrl_pkg::ctrl_t ctrl,
  input  logic bcond,
  input  rv_isa_pkg::word_t imm,
  input  rv_isa_pkg::word_t alu_result,
  output rv_isa_pkg::word_t pc,
  output logic halted
);

  rv_isa_pkg::word_t pc_plus_4;
  rv_isa_pkg::word_t pc_plus_imm;
  rv_isa_pkg::word_t next_pc;

  assign pc_plus_4 = pc + 32'd4;
  assign pc_plus_imm = pc + imm;

  always_comb begin
    if (halted || ctrl.is_ecall) begin
      next_pc = pc; // the ecall stays at instr_addr
    end else if (ctrl.is_jalr) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else if (ctrl.is_jal || (ctrl.branch && bcond)) begin
      next_pc = pc_plus_imm;
    end else begin
      next_pc = pc_plus_4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
      halted <= 1'b0;
    end else begin
      pc <= next_pc;
      halted <= halted | ctrl.is_ecall; // sticky until reset
    end
  end

endmodule

/* instr_decoder.sv */
module instr_decoder (
  input  rv_isa_pkg::word_t instr,
  output cpu_ctrl_pkg::ctrl_t ctrl,
  output cpu_ctrl_pkg::alu_op_t alu_op
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  function automatic cpu_ctrl_pkg::alu_op_t arith_op(input rv_isa_pkg::funct3_t f3);
    cpu_ctrl_pkg::alu_op_t op;
    case (f3)
      rv_isa_pkg::f3_sll: op = cpu_ctrl_pkg::alu_sll;
      rv_isa_pkg::f3_xor: op = cpu_ctrl_pkg::alu_xor;
      rv_isa_pkg::f3_srl: op = cpu_ctrl_pkg::alu_srl;
      rv_isa_pkg::f3_or: op = cpu_ctrl_pkg::alu_or;
      rv_isa_pkg::f3_and: op = cpu_ctrl_pkg::alu_and;
      default: op = cpu_ctrl_pkg::alu_add; // slt and sltu fall back to add
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl = '0;
    case (opcode)
      rv_isa_pkg::op_arith: begin
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::op_arith_imm: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::op_load: begin
        ctrl.mem_read = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src = 1'b1;
      end
      rv_isa_pkg::op_branch: begin
        ctrl.branch = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        ctrl.is_jal = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.pc_to_reg = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        ctrl.is_jalr = 1'b1;
        ctrl.alu_src = 1'b1; // target is rs1 plus the immediate
        ctrl.reg_write = 1'b1;
        ctrl.pc_to_reg = 1'b1;
      end
      rv_isa_pkg::op_ecall: begin
        ctrl.is_ecall = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  always_comb begin
    case (opcode)
      rv_isa_pkg::op_arith: begin
        if (funct7 == rv_isa_pkg::f7_sub) begin
          alu_op = cpu_ctrl_pkg::alu_sub;
        end else begin
          alu_op = arith_op(funct3);
        end
      end
      rv_isa_pkg::op_arith_imm: alu_op = arith_op(funct3);
      rv_isa_pkg::op_branch: alu_op = cpu_ctrl_pkg::alu_sub; // compare by difference
      default: alu_op = cpu_ctrl_pkg::alu_add; // load, store and jalr form an address
    endcase
  end

endmodule

/* imm_gen.sv */
module imm_gen (
  input  rv_isa_pkg::word_t instr,
  output rv_isa_pkg::word_t imm
);

  rv_isa_pkg::opcode_t opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      rv_isa_pkg::op_arith_imm, rv_isa_pkg::op_load, rv_isa_pkg::op_jalr: begin
        imm = {{21{instr[31]}}, instr[30:20]};
      end
      rv_isa_pkg::op_store: begin
        imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      end
      rv_isa_pkg::op_branch: begin
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rv_isa_pkg::op_jal: begin
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0; // R-type and ecall carry no immediate
      end
    endcase
  end

endmodule

/* register_file.sv */
module register_file (
  input  logic clk,
  input  logic reset,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::reg_idx_t rd,
  input  logic write_en,
  input  rv_isa_pkg::word_t write_data,
  output rv_isa_pkg::word_t rs1_data,
  output rv_isa_pkg::word_t rs2_data
);

  rv_isa_pkg::word_t regs [rv_isa_pkg::num_regs];

  // x0 is never written, so it reads as zero after reset
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (rd != '0)) begin
      regs[rd] <= write_data;
    end
  end

endmodule

/* alu.sv */
module alu (
  input  cpu_ctrl_pkg::alu_op_t alu_op,
  input  logic [2:0] funct3,
  input  rv_isa_pkg::word_t in_1,
  input  rv_isa_pkg::word_t in_2,
  output rv_isa_pkg::word_t result,
  output logic bcond
);

  rv_isa_pkg::word_t diff;
  logic [4:0] shamt;

  assign diff = in_1 - in_2;
  assign shamt = in_2[4:0];

  always_comb begin
    case (alu_op)
      cpu_ctrl_pkg::alu_add: result = in_1 + in_2;
      cpu_ctrl_pkg::alu_sub: result = diff;
      cpu_ctrl_pkg::alu_sll: result = in_1 << shamt;
      cpu_ctrl_pkg::alu_xor: result = in_1 ^ in_2;
      cpu_ctrl_pkg::alu_or: result = in_1 | in_2;
      cpu_ctrl_pkg::alu_and: result = in_1 & in_2;
      cpu_ctrl_pkg::alu_srl: result = in_1 >> shamt;
      default: result = '0;
    endcase
  end

  // signed compares use the sign of the difference without overflow correction
  always_comb begin
    bcond = 1'b0;
    if (alu_op == cpu_ctrl_pkg::alu_sub) begin
      case (funct3)
        rv_isa_pkg::f3_beq: bcond = (diff == '0);
        rv_isa_pkg::f3_bne: bcond = (diff != '0);
        rv_isa_pkg::f3_blt: bcond = diff[31];
        rv_isa_pkg::f3_bge: bcond = ~diff[31];
        default: bcond = 1'b0;
      endcase
    end
  end

endmodule

/* rv_core.sv */
module rv_core #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic clk,
  input  logic reset,
  output rv_isa_pkg::word_t instr_addr,
  input  rv_isa_pkg::word_t instr,
  output rv_isa_pkg::word_t dmem_addr,
  output rv_isa_pkg::word_t dmem_wdata,
  input  rv_isa_pkg::word_t dmem_rdata,
  output logic dmem_read,
  output logic dmem_write,
  output logic halted
);

  rv_isa_pkg::word_t pc;
  rv_isa_pkg::word_t pc_plus_4;
  rv_isa_pkg::word_t imm;
  rv_isa_pkg::word_t rs1_data;
  rv_isa_pkg::word_t rs2_data;
  rv_isa_pkg::word_t alu_in_2;
  rv_isa_pkg::word_t alu_result;
  rv_isa_pkg::word_t write_back;
  cpu_ctrl_pkg::ctrl_t ctrl;
  cpu_ctrl_pkg::alu_op_t alu_op;
  logic bcond;
  logic reg_write_en;

  fetch_unit #(
    .reset_pc(reset_pc)
  ) fetch_i (
    .clk(clk),
    .reset(reset),
    .ctrl(ctrl),
    .bcond(bcond),
    .imm(imm),
    .alu_result(alu_result),
    .pc(pc),
    .halted(halted)
  );

  instr_decoder decoder_i (
    .instr(instr),
    .ctrl(ctrl),
    .alu_op(alu_op)
  );

  imm_gen imm_gen_i (
    .instr(instr),
    .imm(imm)
  );

  register_file regs_i (
    .clk(clk),
    .reset(reset),
    .rs1(instr[19:15]),
    .rs2(instr[24:20]),
    .rd(instr[11:7]),
    .write_en(reg_write_en),
    .write_data(write_back),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  alu alu_i (
    .alu_op(alu_op),
    .funct3(instr[14:12]),
    .in_1(rs1_data),
    .in_2(alu_in_2),
    .result(alu_result),
    .bcond(bcond)
  );

  assign instr_addr = pc;
  assign pc_plus_4 = pc + 32'd4; // return address for jal and jalr
  assign alu_in_2 = ctrl.alu_src ? imm : rs2_data;

  always_comb begin
    if (ctrl.pc_to_reg) begin
      write_back = pc_plus_4;
    end else if (ctrl.mem_to_reg) begin
      write_back = dmem_rdata;
    end else begin
      write_back = alu_result;
    end
  end

  // a halted core leaves registers and memory untouched
  assign reg_write_en = ctrl.reg_write & ~halted;
  assign dmem_addr = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_read = ctrl.mem_read & ~reset & ~halted;
  assign dmem_write = ctrl.mem_write & ~reset & ~halted;

endmodule

/* rv_core_assert.sv */
module rv_core_assert (
  input  logic clk,
  input  logic reset,
  input  rv_isa_pkg::word_t instr_addr,
  input  logic dmem_read,
  input  logic dmem_write,
  input  logic halted
);

  no_read_with_write: assert property (@(posedge clk) disable iff (reset)
    !(dmem_read && dmem_write))
    else $error("dmem_read and dmem_write are high in the same cycle");

  fetch_aligned: assert property (@(posedge clk) disable iff (reset)
    instr_addr[1:0] == 2'b00)
    else $error("instr_addr is not word aligned");

  // only reset may clear the halt flag
  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
    else $error("halted dropped without reset");

endmodule

bind rv_core rv_core_assert assert_i (
  .clk(clk),
  .reset(reset),
  .instr_addr(instr_addr),
  .dmem_read(dmem_read),
  .dmem_write(dmem_write),
  .halted(halted)
);

/* tb_rv_core.sv */
module tb_rv_core;

  localparam rv_isa_pkg::word_t reset_pc = 32'h0;
  localparam int timeout_cycles = 256 + 20;
  localparam int mem_base = 'h400; // the 16-word data region

  logic clk;
  logic reset;
  rv_isa_pkg::word_t instr_addr;
  rv_isa_pkg::word_t instr;
  rv_isa_pkg::word_t dmem_addr;
  rv_isa_pkg::word_t dmem_wdata;
  rv_isa_pkg::word_t dmem_rdata;
  logic dmem_read;
  logic dmem_write;
  logic halted;

  rv_isa_pkg::word_t imem [256];
  rv_isa_pkg::word_t dmem [16];
  rv_isa_pkg::word_t m_dmem [16];
  rv_isa_pkg::word_t m_regs [32];
  rv_isa_pkg::word_t m_pc;
  logic m_halted;
  logic exp_read;
  logic exp_write;
  rv_isa_pkg::word_t exp_addr;
  rv_isa_pkg::word_t exp_wdata;
  logic [31:0] rng_state;
  int cycle_count;
  int halt_cycles;

  rv_core #(
    .reset_pc(reset_pc)
  ) dut_i (
    .clk(clk),
    .reset(reset),
    .instr_addr(instr_addr),
    .instr(instr),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata),
    .dmem_read(dmem_read),
    .dmem_write(dmem_write),
    .halted(halted)
  );

  // both memories answer in the same cycle
  assign instr = imem[instr_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[5:2]];

  always @(posedge clk) begin
    if (dmem_write) begin
      dmem[dmem_addr[5:2]] <= dmem_wdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!reset) begin
      cycle_count++;
      if (cycle_count > timeout_cycles) begin
        $display("timeout: the core did not halt within %0d cycles", timeout_cycles);
        $display("Finished with errors");
        $fatal(1, "timeout");
      end
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic rv_isa_pkg::word_t r_format(logic [6:0] f7, logic [4:0] rs2,
                                                 logic [4:0] rs1, logic [2:0] f3,
                                                 logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_isa_pkg::word_t i_format(int imm, logic [4:0] rs1, logic [2:0] f3,
                                                 logic [4:0] rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::word_t s_format(int imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_isa_pkg::word_t b_format(int imm, logic [4:0] rs2, logic [4:0] rs1,
                                                 logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_isa_pkg::word_t j_format(int imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv_isa_pkg::word_t arith_model(logic [2:0] f3, logic is_sub,
                                                    rv_isa_pkg::word_t a,
                                                    rv_isa_pkg::word_t b);
    rv_isa_pkg::word_t res;
    case (f3)
      3'b000: res = is_sub ? a - b : a + b;
      3'b001: res = a << b[4:0]; // shift amount is the low 5 bits
      3'b100: res = a ^ b;
      3'b101: res = a >> b[4:0];
      3'b110: res = a | b;
      3'b111: res = a & b;
      default: res = 32'h0;
    endcase
    return res;
  endfunction

  // jumps and branches only go forward, so every word runs at most once
  task automatic gen_program();
    logic [31:0] r;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    int imm;
    int target;
    int mem_off;
    for (int i = 0; i < 255; i++) begin
      r = next_random();
      rd = {2'b00, r[2:0]};
      rs1 = {2'b00, r[5:3]};
      rs2 = {2'b00, r[8:6]};
      target = i + 1 + int'(next_random() % 32'(255 - i));
      mem_off = mem_base + 4 * int'(r[19:16]);
      f7 = 7'b0000000;
      case (r[15:13])
        3'd0: f3 = 3'b000;
        3'd1: begin
          f3 = 3'b000;
          f7 = 7'b0100000; // sub, or addi for the immediate form
        end
        3'd2: f3 = 3'b001;
        3'd3: f3 = 3'b100;
        3'd4: f3 = 3'b110;
        3'd5: f3 = 3'b111;
        default: f3 = 3'b101;
      endcase
      imm = (f3 == 3'b001 || f3 == 3'b101) ? int'(r[20:16]) : int'(r[27:16]);
      case (r[12:9])
        4'd0, 4'd1, 4'd2, 4'd3: imem[i] = r_format(f7, rs2, rs1, f3, rd);
        4'd4, 4'd5, 4'd6: imem[i] = i_format(imm, rs1, f3, rd, 7'b0010011);
        4'd7, 4'd8: imem[i] = i_format(mem_off, 5'd0, 3'b010, rd, 7'b0000011);
        4'd9, 4'd10: imem[i] = s_format(mem_off, rs2, 5'd0);
        4'd11, 4'd12, 4'd13: begin
          imem[i] = b_format((target - i) * 4, rs2, rs1, {r[14], 1'b0, r[13]});
        end
        4'd14: imem[i] = j_format((target - i) * 4, rd);
        default: imem[i] = i_format(target * 4, 5'd0, 3'b000, rd, 7'b1100111);
      endcase
    end
    imem[255] = 32'h00000073; // ecall
  endtask

  task automatic model_step();
    rv_isa_pkg::word_t ins;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t diff;
    rv_isa_pkg::word_t wb;
    rv_isa_pkg::word_t next_pc;
    logic do_write;
    logic taken;
    logic [4:0] rd;
    exp_read = 1'b0;
    exp_write = 1'b0;
    exp_addr = 32'h0;
    exp_wdata = 32'h0;
    if (m_halted) begin
      return;
    end
    ins = imem[m_pc[9:2]];
    rd = ins[11:7];
    a = m_regs[ins[19:15]];
    b = m_regs[ins[24:20]];
    diff = a - b;
    wb = 32'h0;
    do_write = 1'b0;
    taken = 1'b0;
    next_pc = m_pc + 32'd4;
    case (ins[6:0])
      7'b0110011: begin
        wb = arith_model(ins[14:12], ins[30], a, b);
        do_write = 1'b1;
      end
      7'b0010011: begin
        wb = arith_model(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
        do_write = 1'b1;
      end
      7'b0000011: begin
        exp_read = 1'b1;
        exp_addr = a + {{20{ins[31]}}, ins[31:20]};
        wb = m_dmem[exp_addr[5:2]];
        do_write = 1'b1;
      end
      7'b0100011: begin
        exp_write = 1'b1;
        exp_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        exp_wdata = b;
        m_dmem[exp_addr[5:2]] = b;
      end
      7'b1100011: begin
        case (ins[14:12])
          3'b000: taken = (diff == 32'h0);
          3'b001: taken = (diff != 32'h0);
          3'b100: taken = diff[31]; // sign of the difference, no overflow fix
          3'b101: taken = !diff[31];
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next_pc = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        wb = m_pc + 32'd4;
        do_write = 1'b1;
        next_pc = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1100111: begin
        wb = m_pc + 32'd4;
        do_write = 1'b1;
        next_pc = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'h1;
      end
      default: begin
        m_halted = 1'b1; // ecall holds the pc
        next_pc = m_pc;
      end
    endcase
    if (do_write && rd != 5'd0) begin
      m_regs[rd] = wb;
    end
    m_pc = next_pc;
  endtask

  task automatic check_value(input string name, input rv_isa_pkg::word_t got,
                             input rv_isa_pkg::word_t expected);
    if (got !== expected) begin
      $display("FAIL %s: got %h, expected %h", name, got, expected);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  initial begin
    reset = 1'b1;
    rng_state = 32'd15;
    cycle_count = 0;
    halt_cycles = 0;
    gen_program();
    for (int i = 0; i < 16; i++) begin
      dmem[i] = next_random();
      m_dmem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = 32'h0;
    end
    m_pc = reset_pc;
    m_halted = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("instr_addr", instr_addr, reset_pc);
    check_value("halted", 32'(halted), 32'h0);
    check_value("dmem_write", 32'(dmem_write), 32'h0);
    check_value("dmem_read", 32'(dmem_read), 32'h0);
    reset = 1'b0; // the first instruction executes in this cycle
    while (halt_cycles < 5) begin
      #25;
      check_value("instr_addr", instr_addr, m_pc);
      check_value("halted", 32'(halted), 32'(m_halted));
      model_step();
      check_value("dmem_write", 32'(dmem_write), 32'(exp_write));
      check_value("dmem_read", 32'(dmem_read), 32'(exp_read));
      if (exp_write) begin
        check_value("dmem_addr", dmem_addr, exp_addr);
        check_value("dmem_wdata", dmem_wdata, exp_wdata);
      end
      if (exp_read) begin
        check_value("dmem_addr", dmem_addr, exp_addr);
      end
      if (m_halted) begin
        halt_cycles++;
      end
      @(negedge clk);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* list.f */
rv_isa_pkg.sv
cpu_ctrl_pkg.sv
fetch_unit.sv
instr_decoder.sv
imm_gen.sv
register_file.sv
alu.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f list.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
